/* sim.f */
hw/bpuPkg.sv
hw/branchPredecode.sv
hw/directionPredict.sv
hw/resolveQueue.sv
hw/bpuTop.sv
verification/bpuTop_chk.sv
verification/bpuTb.sv

/* Makefile */
TOP = bpuTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f sim.f \
		--top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

/* verification/bpuTb.sv */
`timescale 1ns/10ps
`default_nettype none

module bpuTb;

    localparam int         NumInstr   = 400;
    localparam int         HoldLength = 24;                   // Resolve pause that drains credits
    localparam int         CycleLimit = NumInstr * 2 * HoldLength;
    localparam int         EntryBits  = 2 * bpuPkg::Xlen + 2; // Taken, backward, target, pc
    localparam logic [6:0] OpAlu      = 7'b0010011;

    logic                       clk = 1'b0;
    logic                       reset;
    logic                       fetchValid;
    logic [bpuPkg::Xlen-1:0]    fetchPc;
    bpuPkg::instrWord           fetchInstr;
    logic                       fetchReady;
    logic                       resolveValid;
    logic                       resolveTaken;
    logic                       predValid;
    logic                       predTaken;
    logic [bpuPkg::Xlen-1:0]    predPc;
    logic                       predRedirect;
    logic                       flush;
    logic [bpuPkg::Xlen-1:0]    flushPc;

    logic [31:0]                lfsr     = 32'd87074;
    logic [bpuPkg::Xlen-1:0]    pcNext   = 32'h8000_0000;
    logic [1:0]                 fwdModel = bpuPkg::CounterInit;
    logic [1:0]                 bwdModel = bpuPkg::CounterInit;
    logic [EntryBits-1:0]       pending [$];  // Predicted branches in program order
    logic [EntryBits-1:0]       resEntry;
    logic                       slotValid = 1'b0;  // Accepted at the coming edge
    bpuPkg::instrWord           slotInstr;
    logic [bpuPkg::Xlen-1:0]    slotPc;
    logic                       predPipeValid = 1'b0;
    logic                       predPipeTaken;
    logic [bpuPkg::Xlen-1:0]    predPipePc;
    logic                       pushDelayValid = 1'b0;
    logic [EntryBits-1:0]       pushDelayEntry;
    logic                       trainAValid = 1'b0;
    logic                       trainATaken;
    logic [EntryBits-1:0]       trainAEntry;
    logic                       trainBValid = 1'b0;
    logic                       trainBTaken;
    logic [EntryBits-1:0]       trainBEntry;
    logic                       runDone = 1'b0;
    int                         issued = 0;
    int                         holdCycles = 0;
    int                         cycle = 0;
    int                         fetchedCount = 0;
    int                         predCount = 0;
    int                         flushCount = 0;
    int                         stallCycles = 0;
    int                         creditsUsed = 0;  // Branches whose credit is still out

    bpuTop dut0 (
        .clk          (clk),
        .reset        (reset),
        .fetchValid   (fetchValid),
        .fetchPc      (fetchPc),
        .fetchInstr   (fetchInstr),
        .fetchReady   (fetchReady),
        .resolveValid (resolveValid),
        .resolveTaken (resolveTaken),
        .predValid    (predValid),
        .predTaken    (predTaken),
        .predPc       (predPc),
        .predRedirect (predRedirect),
        .flush        (flush),
        .flushPc      (flushPc)
    );

    always #20 clk = ~clk;

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    // Galois LFSR, one step per random bit
    function automatic logic stepLfsr();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hB4BC_D35C) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], stepLfsr()};
        end
        return v;
    endfunction

    function automatic bpuPkg::instrWord makeInstr();
        bpuPkg::instrWord w;
        logic [1:0]       kind;
        logic             sign;
        logic             big;
        logic [20:0]      jImm;
        logic [12:0]      bImm;
        kind = 2'(randomBits(2));
        sign = stepLfsr();
        big  = stepLfsr();
        jImm = {sign, big ? 19'(randomBits(19)) : {{15{sign}}, 4'(randomBits(4))}, 1'b0};
        bImm = {sign, big ? 11'(randomBits(11)) : {{7{sign}}, 4'(randomBits(4))}, 1'b0};
        w = randomBits(32);  // Register fields stay random
        if (kind == 2'd2) begin
            w.j.opcode   = bpuPkg::OpJal;
            w.j.imm20    = jImm[20];
            w.j.imm19_12 = jImm[19:12];
            w.j.imm11    = jImm[11];
            w.j.imm10_1  = jImm[10:1];
        end else if (kind == 2'd3) begin
            w.b.opcode = OpAlu;
        end else begin
            w.b.opcode  = bpuPkg::OpBranch;  // Half of all fetches
            w.b.imm12   = bImm[12];
            w.b.imm11   = bImm[11];
            w.b.imm10_5 = bImm[10:5];
            w.b.imm4_1  = bImm[4:1];
        end
        return w;
    endfunction

    function automatic logic [bpuPkg::Xlen-1:0] branchOffset(input bpuPkg::instrWord i);
        return {{19{i.b.imm12}}, i.b.imm12, i.b.imm11, i.b.imm10_5, i.b.imm4_1, 1'b0};
    endfunction

    function automatic logic [bpuPkg::Xlen-1:0] jumpOffset(input bpuPkg::instrWord i);
        return {{11{i.j.imm20}}, i.j.imm20, i.j.imm19_12, i.j.imm11, i.j.imm10_1, 1'b0};
    endfunction

    // Reference prediction, {taken, next pc}
    function automatic logic [bpuPkg::Xlen:0] predictNext(input bpuPkg::instrWord instr,
        input logic [bpuPkg::Xlen-1:0] pc, input logic [1:0] fwd, input logic [1:0] bwd);
        logic [bpuPkg::Xlen-1:0] off;
        logic [1:0]              cnt;
        if (instr.j.opcode == bpuPkg::OpJal) begin
            return {1'b1, pc + jumpOffset(instr)};
        end
        if (instr.b.opcode == bpuPkg::OpBranch) begin
            off = branchOffset(instr);
            cnt = off[bpuPkg::Xlen-1] ? bwd : fwd;
            if (cnt >= bpuPkg::TakenThreshold) begin
                return {1'b1, pc + off};
            end
        end
        return {1'b0, pc + 32'd4};
    endfunction

    function automatic logic [1:0] saturate(input logic [1:0] cnt, input logic up);
        if (up) begin
            return (cnt == 2'b11) ? cnt : cnt + 2'b01;
        end
        return (cnt == 2'b00) ? cnt : cnt - 2'b01;
    endfunction

    task automatic trainModel(input logic backward, input logic up);
        if (backward) begin
            bwdModel = saturate(bwdModel, up);
        end else begin
            fwdModel = saturate(fwdModel, up);
        end
    endtask

    task automatic checkPrediction(input logic expTaken, input logic [bpuPkg::Xlen-1:0] expPc);
        if (predTaken !== expTaken || predRedirect !== expTaken) begin
            abortRun($sformatf("[FAIL] %0t: predTaken %b predRedirect %b, expected %b",
                               $time, predTaken, predRedirect, expTaken));
        end
        if (predPc !== expPc) begin
            abortRun($sformatf("[FAIL] %0t: predPc %h, expected %h", $time, predPc, expPc));
        end
    endtask

    task automatic checkFlush(input logic expFlush, input logic [bpuPkg::Xlen-1:0] expPc);
        if (flush !== expFlush) begin
            abortRun($sformatf("[FAIL] %0t: flush %b, expected %b", $time, flush, expFlush));
        end
        if (expFlush && flushPc !== expPc) begin
            abortRun($sformatf("[FAIL] %0t: flushPc %h, expected %h", $time, flushPc, expPc));
        end
    endtask

    // Fetch and execute models, driven on the rising edge
    always @(posedge clk) begin
        if (!reset) begin
            if (slotValid || !fetchValid) begin
                if (issued < NumInstr && randomBits(2) != 0) begin
                    fetchInstr <= makeInstr();
                    fetchPc    <= pcNext;
                    fetchValid <= 1'b1;
                    pcNext     = pcNext + 32'd4;
                    issued++;
                end else begin
                    fetchValid <= 1'b0;
                end
            end
            if (holdCycles != 0) begin
                holdCycles--;
                resolveValid <= 1'b0;
            end else if (randomBits(4) == 0) begin
                holdCycles   = HoldLength;
                resolveValid <= 1'b0;
            end else if (pending.size() != 0 && stepLfsr()) begin
                resEntry     = pending.pop_front();
                resolveValid <= 1'b1;
                resolveTaken <= stepLfsr();
            end else begin
                resolveValid <= 1'b0;
            end
        end
    end

    // Compare process, samples between edges
    always @(negedge clk) begin
        logic [bpuPkg::Xlen:0]   guess;
        logic [bpuPkg::Xlen-1:0] off;
        logic [bpuPkg::Xlen-1:0] fixPc;
        if (!reset) begin
            cycle++;
            if (cycle > CycleLimit) begin
                abortRun("Timeout: the run did not finish within the cycle limit");
            end
            if (dut0.chk0.assertFails != 0) begin
                abortRun("An assertion in the bound checker failed");
            end
            if (trainBValid) begin
                trainModel(trainBEntry[2*bpuPkg::Xlen], trainBTaken);  // Counter moved at this edge
                creditsUsed--;  // Credit returned at the same edge
            end
            if (slotValid && slotInstr.b.opcode == bpuPkg::OpBranch) begin
                creditsUsed++;  // Taken by the branch accepted at this edge
            end
            if (fetchReady !== (creditsUsed < bpuPkg::QueueDepth)) begin
                abortRun($sformatf("[FAIL] %0t: fetchReady %b with %0d credits in use",
                                   $time, fetchReady, creditsUsed));
            end
            trainBValid = trainAValid;
            trainBTaken = trainATaken;
            trainBEntry = trainAEntry;
            trainAValid = resolveValid;
            trainATaken = resolveTaken;
            trainAEntry = resEntry;
            if (trainBValid && trainBEntry[2*bpuPkg::Xlen+1] != trainBTaken) begin
                fixPc = trainBTaken ? trainBEntry[2*bpuPkg::Xlen-1:bpuPkg::Xlen]
                                    : trainBEntry[bpuPkg::Xlen-1:0] + 32'd4;
                checkFlush(1'b1, fixPc);
                flushCount++;
            end else begin
                checkFlush(1'b0, '0);
            end
            if (predValid !== predPipeValid) begin
                abortRun($sformatf("[FAIL] %0t: predValid %b, expected %b",
                                   $time, predValid, predPipeValid));
            end
            if (!predPipeValid && predRedirect !== 1'b0) begin
                abortRun($sformatf("[FAIL] %0t: predRedirect %b without a prediction",
                                   $time, predRedirect));
            end
            if (predPipeValid) begin
                checkPrediction(predPipeTaken, predPipePc);
                predCount++;
            end
            if (pushDelayValid) begin
                pending.push_back(pushDelayEntry);  // Queue entry now written in the DUT
            end
            predPipeValid  = slotValid;
            pushDelayValid = slotValid && (slotInstr.b.opcode == bpuPkg::OpBranch);
            if (slotValid) begin
                guess          = predictNext(slotInstr, slotPc, fwdModel, bwdModel);
                predPipeTaken  = guess[bpuPkg::Xlen];
                predPipePc     = guess[bpuPkg::Xlen-1:0];
                off            = branchOffset(slotInstr);
                pushDelayEntry = {predPipeTaken, off[bpuPkg::Xlen-1], slotPc + off, slotPc};
            end
            slotValid = fetchValid && fetchReady;
            slotInstr = fetchInstr;
            slotPc    = fetchPc;
            if (slotValid) begin
                fetchedCount++;
            end
            if (fetchValid && !fetchReady) begin
                stallCycles++;  // Credits exhausted
            end
            if (fetchedCount == NumInstr && !slotValid && !predPipeValid && !pushDelayValid
                && pending.size() == 0 && !trainAValid && !resolveValid) begin
                runDone = 1'b1;
            end
        end
    end

    initial begin
        reset        = 1'b1;
        fetchValid   = 1'b0;
        fetchPc      = '0;
        fetchInstr   = '0;
        resolveValid = 1'b0;
        resolveTaken = 1'b0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (fetchReady !== 1'b1) begin
            abortRun($sformatf("[FAIL] %0t: fetchReady low after reset", $time));
        end
        wait (runDone);
        $display("Checked %0d predictions, %0d flushes, %0d stalled fetch cycles",
                 predCount, flushCount, stallCycles);
        if (predCount == NumInstr && flushCount != 0 && stallCycles != 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            abortRun("The run ended without every prediction, a flush and a credit stall");
        end
    end

endmodule

`default_nettype wire

/* verification/bpuTop_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module bpuTop_chk (
    input wire                              clk,
    input wire                              reset,
    input wire [bpuPkg::CreditWidth-1:0]    credits,
    input wire [bpuPkg::CreditWidth-1:0]    occupancy,
    input wire                              resolveValid,
    input wire                              flush
);

    int assertFails = 0;  // Read by the testbench monitor

    // A queued branch still holds its credit, so both together never exceed the slots
    creditsBounded: assert property (@(posedge clk) disable iff (reset)
        (int'(credits) + int'(occupancy)) <= bpuPkg::QueueDepth)
        else begin
            assertFails++;
            $error("Credits plus queued branches exceed the queue depth");
        end

    resolveNeedsBranch: assert property (@(posedge clk) disable iff (reset)
        resolveValid |-> (occupancy != '0))
        else begin
            assertFails++;
            $error("Resolve reported with no branch pending");
        end

    // Flush is the registered result of a resolve at the edge before
    flushAfterResolve: assert property (@(posedge clk) disable iff (reset)
        $rose(flush) |-> $past(resolveValid))
        else begin
            assertFails++;
            $error("Flush raised without a preceding resolve");
        end

endmodule

bind bpuTop bpuTop_chk chk0 (
    .clk          (clk),
    .reset        (reset),
    .credits      (predecode0.credits),
    .occupancy    (queue0.occupancy),
    .resolveValid (resolveValid),
    .flush        (flush)
);

`default_nettype wire

/* hw/bpuTop.sv */
`timescale 1ns/10ps
`default_nettype none

module bpuTop (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          fetchValid,
    input  wire  [bpuPkg::Xlen-1:0]      fetchPc,
    input  wire  bpuPkg::instrWord       fetchInstr,
    output logic                         fetchReady,
    input  wire                          resolveValid,
    input  wire                          resolveTaken,
    output logic                         predValid,
    output logic                         predTaken,
    output logic [bpuPkg::Xlen-1:0]      predPc,
    output logic                         predRedirect,
    output logic                         flush,
    output logic [bpuPkg::Xlen-1:0]      flushPc
);

    // Predecode to predict
    logic                      decValid;
    logic                      decBranch;
    logic                      decJal;
    logic                      decBackward;
    logic [bpuPkg::Xlen-1:0]   decPc;
    logic [bpuPkg::Xlen-1:0]   decTarget;

    // Predict to queue
    logic                      pushValid;
    logic                      pushTaken;
    logic                      pushBackward;
    logic [bpuPkg::Xlen-1:0]   pushPc;
    logic [bpuPkg::Xlen-1:0]   pushTarget;

    // Queue back to the earlier stages
    logic                      trainValid;
    logic                      trainBackward;
    logic                      trainUp;
    logic                      creditReturn;

    branchPredecode predecode0 (
        .clk          (clk),
        .reset        (reset),
        .fetchValid   (fetchValid),
        .fetchPc      (fetchPc),
        .fetchInstr   (fetchInstr),
        .creditReturn (creditReturn),
        .fetchReady   (fetchReady),
        .decValid     (decValid),
        .decBranch    (decBranch),
        .decJal       (decJal),
        .decBackward  (decBackward),
        .decPc        (decPc),
        .decTarget    (decTarget)
    );

    directionPredict predict0 (
        .clk           (clk),
        .reset         (reset),
        .decValid      (decValid),
        .decBranch     (decBranch),
        .decJal        (decJal),
        .decBackward   (decBackward),
        .decPc         (decPc),
        .decTarget     (decTarget),
        .trainValid    (trainValid),
        .trainBackward (trainBackward),
        .trainUp       (trainUp),
        .predValid     (predValid),
        .predTaken     (predTaken),
        .predPc        (predPc),
        .predRedirect  (predRedirect),
        .pushValid     (pushValid),
        .pushTaken     (pushTaken),
        .pushBackward  (pushBackward),
        .pushPc        (pushPc),
        .pushTarget    (pushTarget)
    );

    resolveQueue queue0 (
        .clk           (clk),
        .reset         (reset),
        .pushValid     (pushValid),
        .pushTaken     (pushTaken),
        .pushBackward  (pushBackward),
        .pushPc        (pushPc),
        .pushTarget    (pushTarget),
        .resolveValid  (resolveValid),
        .resolveTaken  (resolveTaken),
        .flush         (flush),
        .flushPc       (flushPc),
        .trainValid    (trainValid),
        .trainBackward (trainBackward),
        .trainUp       (trainUp),
        .creditReturn  (creditReturn)
    );

endmodule

`default_nettype wire

/* hw/resolveQueue.sv */
`timescale 1ns/10ps
`default_nettype none

module resolveQueue (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          pushValid,
    input  wire                          pushTaken,
    input  wire                          pushBackward,
    input  wire  [bpuPkg::Xlen-1:0]      pushPc,
    input  wire  [bpuPkg::Xlen-1:0]      pushTarget,
    input  wire                          resolveValid,
    input  wire                          resolveTaken,
    output logic                         flush,
    output logic [bpuPkg::Xlen-1:0]      flushPc,
    output logic                         trainValid,
    output logic                         trainBackward,
    output logic                         trainUp,
    output logic                         creditReturn
);

    // Entry storage
    logic                      qTaken    [0:bpuPkg::QueueDepth-1];
    logic                      qBackward [0:bpuPkg::QueueDepth-1];
    logic [bpuPkg::Xlen-1:0]   qPc       [0:bpuPkg::QueueDepth-1];
    logic [bpuPkg::Xlen-1:0]   qTarget   [0:bpuPkg::QueueDepth-1];

    logic [bpuPkg::PtrWidth-1:0]      head;
    logic [bpuPkg::PtrWidth-1:0]      tail;
    logic [bpuPkg::CreditWidth-1:0]   occupancy;
    logic                             queueEmpty;
    logic                             pop;

    logic                      headTaken;
    logic                      headBackward;
    logic [bpuPkg::Xlen-1:0]   headPc;
    logic [bpuPkg::Xlen-1:0]   headTarget;
    logic                      mismatch;

    assign queueEmpty = (occupancy == '0);
    assign pop        = resolveValid && !queueEmpty;  // Stray reports are ignored

    assign headTaken    = qTaken[head];
    assign headBackward = qBackward[head];
    assign headPc       = qPc[head];
    assign headTarget   = qTarget[head];
    assign mismatch     = (headTaken != resolveTaken);

    always_ff @(posedge clk) begin
        if (pushValid) begin
            qTaken[tail]    <= pushTaken;
            qBackward[tail] <= pushBackward;
            qPc[tail]       <= pushPc;
            qTarget[tail]   <= pushTarget;
        end
    end

    // Pointers wrap at the last slot
    always_ff @(posedge clk) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (pushValid) begin
                tail <= (tail == bpuPkg::LastSlot) ? '0 : tail + 1'b1;
            end
            if (pop) begin
                head <= (head == bpuPkg::LastSlot) ? '0 : head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            occupancy <= '0;
        end else begin
            case ({pushValid, pop})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;  // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            flush        <= 1'b0;
            trainValid   <= 1'b0;
            creditReturn <= 1'b0;
        end else begin
            flush        <= pop && mismatch;
            trainValid   <= pop;
            creditReturn <= pop;  // Slot freed, hand the credit back
        end
    end

    // Counter moves with the real outcome, so it follows a correct
    // prediction and backs away from a wrong one
    always_ff @(posedge clk) begin
        if (pop) begin
            flushPc       <= resolveTaken ? headTarget : headPc + bpuPkg::InstrBytes;
            trainBackward <= headBackward;
            trainUp       <= resolveTaken;
        end
    end

endmodule

`default_nettype wire

/* hw/directionPredict.sv */
`timescale 1ns/10ps
`default_nettype none

module directionPredict (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          decValid,
    input  wire                          decBranch,
    input  wire                          decJal,
    input  wire                          decBackward,
    input  wire  [bpuPkg::Xlen-1:0]      decPc,
    input  wire  [bpuPkg::Xlen-1:0]      decTarget,
    input  wire                          trainValid,
    input  wire                          trainBackward,
    input  wire                          trainUp,
    output logic                         predValid,
    output logic                         predTaken,
    output logic [bpuPkg::Xlen-1:0]      predPc,
    output logic                         predRedirect,
    output logic                         pushValid,
    output logic                         pushTaken,
    output logic                         pushBackward,
    output logic [bpuPkg::Xlen-1:0]      pushPc,
    output logic [bpuPkg::Xlen-1:0]      pushTarget
);

    logic [1:0]                fwdCounter;
    logic [1:0]                bwdCounter;
    logic [1:0]                selCounter;
    logic                      taken;
    logic [bpuPkg::Xlen-1:0]   nextPc;

    // Saturating step, stops at 0 and 3
    function automatic logic [1:0] satStep(input logic [1:0] cnt, input logic up);
        logic [1:0] result;
        result = cnt;
        if (up && cnt != 2'b11) begin
            result = cnt + 2'b01;
        end else if (!up && cnt != 2'b00) begin
            result = cnt - 2'b01;
        end
        return result;
    endfunction

    // Training from the resolve queue
    always_ff @(posedge clk) begin
        if (reset) begin
            fwdCounter <= bpuPkg::CounterInit;
            bwdCounter <= bpuPkg::CounterInit;
        end else if (trainValid) begin
            if (trainBackward) begin
                bwdCounter <= satStep(bwdCounter, trainUp);
            end else begin
                fwdCounter <= satStep(fwdCounter, trainUp);
            end
        end
    end

    assign selCounter = decBackward ? bwdCounter : fwdCounter;

    always_comb begin
        if (decJal) begin
            taken = 1'b1;  // Unconditional
        end else if (decBranch) begin
            taken = (selCounter >= bpuPkg::TakenThreshold);
        end else begin
            taken = 1'b0;
        end
    end

    assign nextPc = taken ? decTarget : decPc + bpuPkg::InstrBytes;

    always_ff @(posedge clk) begin
        if (reset) begin
            predValid    <= 1'b0;
            predRedirect <= 1'b0;
            pushValid    <= 1'b0;
        end else begin
            predValid    <= decValid;
            predRedirect <= decValid && taken;  // Early redirect of fetch
            pushValid    <= decValid && decBranch;
        end
    end

    always_ff @(posedge clk) begin
        if (decValid) begin
            predTaken <= taken;
            predPc    <= nextPc;
        end
    end

    // Queue entry for conditional branches
    always_ff @(posedge clk) begin
        if (decValid && decBranch) begin
            pushTaken    <= taken;
            pushBackward <= decBackward;
            pushPc       <= decPc;
            pushTarget   <= decTarget;
        end
    end

endmodule

`default_nettype wire

/* hw/branchPredecode.sv */
`timescale 1ns/10ps
`default_nettype none

module branchPredecode (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              fetchValid,
    input  wire        [bpuPkg::Xlen-1:0]    fetchPc,
    input  wire bpuPkg::instrWord            fetchInstr,
    input  wire                              creditReturn,
    output logic                             fetchReady,
    output logic                             decValid,
    output logic                             decBranch,
    output logic                             decJal,
    output logic                             decBackward,
    output logic       [bpuPkg::Xlen-1:0]    decPc,
    output logic       [bpuPkg::Xlen-1:0]    decTarget
);

    logic                             isBranch;
    logic                             isJal;
    logic                             accept;
    logic                             spend;
    logic [bpuPkg::Xlen-1:0]          bOffset;
    logic [bpuPkg::Xlen-1:0]          jOffset;
    logic [bpuPkg::Xlen-1:0]          offset;
    logic [bpuPkg::CreditWidth-1:0]   credits;

    // Both views share the opcode field
    assign isBranch = (fetchInstr.b.opcode == bpuPkg::OpBranch);
    assign isJal    = (fetchInstr.j.opcode == bpuPkg::OpJal);

    // B-type immediate, bit 12 is the sign
    assign bOffset = {{(bpuPkg::Xlen - 12){fetchInstr.b.imm12}},
                      fetchInstr.b.imm11,
                      fetchInstr.b.imm10_5,
                      fetchInstr.b.imm4_1,
                      1'b0};

    // J-type immediate, bit 20 is the sign
    assign jOffset = {{(bpuPkg::Xlen - 20){fetchInstr.j.imm20}},
                      fetchInstr.j.imm19_12,
                      fetchInstr.j.imm11,
                      fetchInstr.j.imm10_1,
                      1'b0};

    assign offset = isJal ? jOffset : bOffset;

    // Hold everything while no credit is left
    assign fetchReady = (credits != '0);
    assign accept     = fetchValid && fetchReady;
    assign spend      = accept && isBranch;  // Only conditional branches take a slot

    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= bpuPkg::CreditWidth'(bpuPkg::QueueDepth);
        end else if (spend && !creditReturn) begin
            credits <= credits - 1'b1;
        end else if (creditReturn && !spend) begin
            credits <= credits + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decValid  <= 1'b0;
            decBranch <= 1'b0;
            decJal    <= 1'b0;
        end else begin
            decValid  <= accept;
            decBranch <= accept && isBranch;
            decJal    <= accept && isJal;
        end
    end

    // Payload follows decValid
    always_ff @(posedge clk) begin
        if (accept) begin
            decBackward <= offset[bpuPkg::Xlen-1];  // Negative offset jumps back
            decPc       <= fetchPc;
            decTarget   <= fetchPc + offset;
        end
    end

endmodule

`default_nettype wire

/* hw/bpuPkg.sv */
`default_nettype none

package bpuPkg;

    // Datapath and queue sizing
    localparam int Xlen        = 32;
    localparam int QueueDepth  = 8;                       // Pending branches, also credits
    localparam int CreditWidth = $clog2(QueueDepth + 1);  // Holds 0..QueueDepth
    localparam int PtrWidth    = $clog2(QueueDepth);

    localparam logic [PtrWidth-1:0] LastSlot   = PtrWidth'(QueueDepth - 1);
    localparam logic [Xlen-1:0]     InstrBytes = Xlen'(4);  // Fall-through step

    // Major opcodes
    localparam logic [6:0] OpBranch = 7'b1100011;
    localparam logic [6:0] OpJal    = 7'b1101111;

    // Two-bit direction counters
    localparam logic [1:0] CounterInit    = 2'b10;  // Weakly taken
    localparam logic [1:0] TakenThreshold = 2'b10;

    // One fetched word, read as B-type or as J-type
    typedef union packed {
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } instrWord;

endpackage

`default_nettype wire
